// File: hw/triangle_pkg.sv
//--------------------------------------------------------------------------
// triangle generator package: shared widths and the words passed between
// the phase generator, shaper, crossing detector and output combiner
//--------------------------------------------------------------------------
`default_nettype none

package triangle_pkg;

  // independent triangle channels
  localparam int channels = 2;
  // samples per channel delivered on every dac_clk
  localparam int parallel_samples = 4;
  // phase accumulator width, sets the frequency resolution
  localparam int phase_bits = 24;
  // DAC sample width
  localparam int sample_width = 16;

  // phase of every sample of every channel in one clock
  typedef struct packed {
    logic [channels-1:0][parallel_samples-1:0][phase_bits-1:0] phase;
  } phase_word_t;

  // per-channel phase increment as written by software
  typedef logic [channels-1:0][phase_bits-1:0] phase_inc_t;

  // shaped samples, one clock worth
  typedef logic [channels-1:0][parallel_samples-1:0][sample_width-1:0] sample_array_t;

  // word handed to the DAC every clock
  // trigger marks the upward mid-scale crossing of each channel
  typedef struct packed {
    logic                valid;
    logic [channels-1:0] trigger;
    sample_array_t       data;
  } dac_word_t;

endpackage

`default_nettype wire

// File: hw/parallel_phase_gen.sv
//--------------------------------------------------------------------------
// parallel phase accumulator, parallel_samples phases per channel per clock
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module parallel_phase_gen #(
  parameter int channels         = triangle_pkg::channels,
  parameter int parallel_samples = triangle_pkg::parallel_samples,
  parameter int phase_bits       = triangle_pkg::phase_bits
) (
  input  wire                       dac_clk,
  input  wire                       dac_reset,
  input  wire                       phase_inc_load,
  input  wire triangle_pkg::phase_inc_t phase_inc,
  output triangle_pkg::phase_word_t phase_word,
  output logic                      phase_valid
);

  // multiples of the increment, entry s holds inc * (s + 1)
  // last entry is the step of the cycle phase per clock
  logic [channels-1:0][parallel_samples-1:0][phase_bits-1:0] inc_mult;

  // phase of sample 0 for the next phase word
  logic [channels-1:0][phase_bits-1:0] cycle_phase;

  // increment multiples
  // only updated on a load strobe, every load is accepted
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      inc_mult <= '0;
    end else if (phase_inc_load) begin
      for (int ch = 0; ch < channels; ch++) begin
        for (int s = 0; s < parallel_samples; s++) begin
          // wraps modulo 2^phase_bits like the accumulator
          inc_mult[ch][s] <= phase_bits'(phase_inc[ch] * (s + 1));
        end
      end
    end
  end

  // accumulator
  // steps by parallel_samples increments so each word picks up
  // right where the previous one ended
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      cycle_phase <= '0;
    end else begin
      for (int ch = 0; ch < channels; ch++) begin
        cycle_phase[ch] <= cycle_phase[ch] + inc_mult[ch][parallel_samples-1];
      end
    end
  end

  // phase word
  // sample 0 is the cycle phase itself, later samples add the lower multiples
  // uses the old cycle phase, so the word trails the accumulator by one clock
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      phase_word <= '0;
    end else begin
      for (int ch = 0; ch < channels; ch++) begin
        phase_word.phase[ch][0] <= cycle_phase[ch];
        for (int s = 1; s < parallel_samples; s++) begin
          phase_word.phase[ch][s] <= cycle_phase[ch] + inc_mult[ch][s-1];
        end
      end
    end
  end

  // valid level
  // a zero increment still gives a legal (flat) word, so valid
  // does not wait for the first load
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      phase_valid <= 1'b0;
    end else begin
      phase_valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/triangle_shaper.sv
//--------------------------------------------------------------------------
// triangle shaper: folds each phase into a triangle sample, one clock
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module triangle_shaper #(
  parameter int channels         = triangle_pkg::channels,
  parameter int parallel_samples = triangle_pkg::parallel_samples,
  parameter int phase_bits       = triangle_pkg::phase_bits,
  parameter int sample_width     = triangle_pkg::sample_width
) (
  input  wire                          dac_clk,
  input  wire                          dac_reset,
  input  wire triangle_pkg::phase_word_t phase_word,
  input  wire                          phase_valid,
  output triangle_pkg::sample_array_t  shaped,
  output logic                         shaped_valid
);

  // mid-scale and the value just below it, full precision
  localparam logic [phase_bits-1:0] mid_scale = {1'b1, {(phase_bits-1){1'b0}}};
  localparam logic [phase_bits-1:0] below_mid = {1'b0, {(phase_bits-1){1'b1}}};

  // full-precision triangle value per sample
  logic [channels-1:0][parallel_samples-1:0][phase_bits-1:0] full_value;
  // twice the phase with the MSB dropped
  logic [channels-1:0][parallel_samples-1:0][phase_bits-1:0] twice_low;

  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        twice_low[ch][s] = {phase_word.phase[ch][s][phase_bits-2:0], 1'b0};
        // first half of the period ramps up from mid-scale to full scale
        // then wraps through zero and ramps back up to mid-scale
        // second half mirrors it, so the result ramps down
        if (!phase_word.phase[ch][s][phase_bits-1]) begin
          full_value[ch][s] = mid_scale + twice_low[ch][s];
        end else begin
          full_value[ch][s] = below_mid - twice_low[ch][s];
        end
      end
    end
  end

  // keep the top sample_width bits
  // plain truncation, the low bits only matter for very slow sweeps
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        shaped[ch][s] <= full_value[ch][s][phase_bits-1-:sample_width];
      end
    end
  end

  // valid follows the phase word by the same single stage
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      shaped_valid <= 1'b0;
    end else begin
      shaped_valid <= phase_valid;
    end
  end

  // the DAC stream cannot pause, so once started it runs until reset
  assert property (@(posedge dac_clk) disable iff (dac_reset)
    shaped_valid |=> shaped_valid)
    else $error("shaped_valid dropped outside reset");

endmodule

`default_nettype wire

// File: hw/crossing_detector.sv
//--------------------------------------------------------------------------
// upward mid-scale crossing trigger per channel, from the phase quadrant
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module crossing_detector #(
  parameter int channels         = triangle_pkg::channels,
  parameter int parallel_samples = triangle_pkg::parallel_samples,
  parameter int phase_bits       = triangle_pkg::phase_bits
) (
  input  wire                          dac_clk,
  input  wire                          dac_reset,
  input  wire triangle_pkg::phase_word_t phase_word,
  output logic [channels-1:0]          trigger
);

  // phase MSB, high on the falling half of the triangle
  logic [channels-1:0][parallel_samples-1:0] half_bit;
  // second phase bit, high once the rising half passes mid-scale
  logic [channels-1:0][parallel_samples-1:0] quad_bit;
  logic [channels-1:0]                       crossing;

  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        half_bit[ch][s] = phase_word.phase[ch][s][phase_bits-1];
        quad_bit[ch][s] = phase_word.phase[ch][s][phase_bits-2];
      end
      // whole word on the rising half, and it straddles the
      // first to second quadrant boundary
      // only exact when the phase moves less than a quadrant per word
      crossing[ch] = ~(|half_bit[ch]) & (|quad_bit[ch]) & ~(&quad_bit[ch]);
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      trigger <= '0;
    end else begin
      trigger <= crossing;
    end
  end

  // trigger goes out to other instruments, no glitch may leave during reset
  assert property (@(posedge dac_clk) dac_reset |=> (trigger == '0))
    else $error("trigger set after reset");

endmodule

`default_nettype wire

// File: hw/sample_combiner.sv
//--------------------------------------------------------------------------
// registers shaped samples, triggers and valid into one aligned DAC word
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sample_combiner #(
  parameter int channels         = triangle_pkg::channels,
  parameter int parallel_samples = triangle_pkg::parallel_samples,
  parameter int sample_width     = triangle_pkg::sample_width
) (
  input  wire                            dac_clk,
  input  wire                            dac_reset,
  input  wire triangle_pkg::sample_array_t shaped,
  input  wire                            shaped_valid,
  input  wire [channels-1:0]             trigger,
  output triangle_pkg::dac_word_t        dac_out
);

  // shaper and detector both sit one stage after the phase word,
  // so their outputs already line up here

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      dac_out <= '0;
    end else begin
      dac_out.valid   <= shaped_valid;
      dac_out.trigger <= trigger;
      for (int ch = 0; ch < channels; ch++) begin
        for (int s = 0; s < parallel_samples; s++) begin
          // idle words carry zero, the shaper data has no reset of its own
          if (shaped_valid) begin
            dac_out.data[ch][s] <= shaped[ch][s];
          end else begin
            dac_out.data[ch][s] <= {sample_width{1'b0}};
          end
        end
      end
    end
  end

  // detector and shaper must agree on which words are live
  // a trigger in an idle word would fire before the sweep starts
  assert property (@(posedge dac_clk) disable iff (dac_reset)
    (|trigger) |-> shaped_valid)
    else $error("trigger raised in a word without valid");

  // same rule on the registered word
  assert property (@(posedge dac_clk) (|dac_out.trigger) |-> dac_out.valid)
    else $error("output word has trigger without valid");

endmodule

`default_nettype wire

// File: hw/triangle_gen_top.sv
//--------------------------------------------------------------------------
// multi-channel triangle generator for a parallel-sample DAC
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module triangle_gen_top #(
  parameter int channels         = triangle_pkg::channels,
  parameter int parallel_samples = triangle_pkg::parallel_samples,
  parameter int phase_bits       = triangle_pkg::phase_bits,
  parameter int sample_width     = triangle_pkg::sample_width
) (
  input  wire                           dac_clk,
  input  wire                           dac_reset,
  // one-cycle strobe, phase_inc is taken on the same edge
  input  wire                           phase_inc_load,
  input  wire triangle_pkg::phase_inc_t phase_inc,
  output triangle_pkg::dac_word_t       dac_out
);

  // generator to shaper and detector
  triangle_pkg::phase_word_t   phase_word;
  logic                        phase_valid;

  // shaper and detector to combiner
  triangle_pkg::sample_array_t shaped;
  logic                        shaped_valid;
  logic [channels-1:0]         trigger;

  parallel_phase_gen #(
    .channels         (channels),
    .parallel_samples (parallel_samples),
    .phase_bits       (phase_bits)
  ) phase_gen_i (
    .dac_clk        (dac_clk),
    .dac_reset      (dac_reset),
    .phase_inc_load (phase_inc_load),
    .phase_inc      (phase_inc),
    .phase_word     (phase_word),
    .phase_valid    (phase_valid)
  );

  triangle_shaper #(
    .channels         (channels),
    .parallel_samples (parallel_samples),
    .phase_bits       (phase_bits),
    .sample_width     (sample_width)
  ) shaper_i (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .phase_word   (phase_word),
    .phase_valid  (phase_valid),
    .shaped       (shaped),
    .shaped_valid (shaped_valid)
  );

  // runs beside the shaper on the same phase word
  crossing_detector #(
    .channels         (channels),
    .parallel_samples (parallel_samples),
    .phase_bits       (phase_bits)
  ) detector_i (
    .dac_clk    (dac_clk),
    .dac_reset  (dac_reset),
    .phase_word (phase_word),
    .trigger    (trigger)
  );

  sample_combiner #(
    .channels         (channels),
    .parallel_samples (parallel_samples),
    .sample_width     (sample_width)
  ) combiner_i (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .shaped       (shaped),
    .shaped_valid (shaped_valid),
    .trigger      (trigger),
    .dac_out      (dac_out)
  );

endmodule

`default_nettype wire

// File: tb/triangle_gen_tb.sv
//--------------------------------------------------------------------------
// testbench for the triangle generator: reference phase model plus
// concurrent checks on every DAC word
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module triangle_gen_tb;

  localparam int channels         = triangle_pkg::channels;
  localparam int parallel_samples = triangle_pkg::parallel_samples;
  localparam int phase_bits       = triangle_pkg::phase_bits;
  localparam int sample_width     = triangle_pkg::sample_width;

  localparam int full_scale = 1 << phase_bits;
  localparam int quarter    = 1 << (phase_bits - 2);

  // test lengths in clocks
  // trigger test is bounded by the longest slow period plus its own reset
  localparam int reset_cycles   = 12;
  localparam int zero_cycles    = 40;
  localparam int shape_cycles   = 400;
  localparam int reload_cycles  = 400;
  localparam int trigger_cycles = 1040;
  localparam int cycle_limit    = (reset_cycles + zero_cycles + shape_cycles +
                                   reload_cycles + trigger_cycles) * 3 / 2;

  logic                        dac_clk = 1'b0;
  logic                        dac_reset;
  logic                        phase_inc_load;
  triangle_pkg::phase_inc_t    phase_inc;
  triangle_pkg::dac_word_t     dac_out;

  int    test_id;
  string test_name;
  int    cycle_count = 0;
  int    edges_since_release = 0;
  int    valid_errs = 0;
  int    idle_errs = 0;
  int    data_errs = 0;
  int    trig_errs = 0;
  int    phase_errs = 0;

  // reference model state, same update rules as the generator
  triangle_pkg::phase_inc_t            m_inc;
  logic [channels-1:0][phase_bits-1:0] m_cycle;
  triangle_pkg::phase_word_t           m_phase;
  logic                                m_valid;
  // two-stage delay to line up with dac_out
  triangle_pkg::phase_word_t           d1_phase;
  triangle_pkg::phase_word_t           d2_phase;
  logic                                d1_valid;
  logic                                d2_valid;
  triangle_pkg::dac_word_t             exp_word;
  triangle_pkg::sample_array_t         mid_fill;

  triangle_gen_top #(
    .channels         (channels),
    .parallel_samples (parallel_samples),
    .phase_bits       (phase_bits),
    .sample_width     (sample_width)
  ) dut_i (
    .dac_clk        (dac_clk),
    .dac_reset      (dac_reset),
    .phase_inc_load (phase_inc_load),
    .phase_inc      (phase_inc),
    .dac_out        (dac_out)
  );

  always #2 dac_clk = ~dac_clk;

  // rising half counts up from mid-scale, falling half mirrors it
  function automatic logic [sample_width-1:0] fold_sample(input logic [phase_bits-1:0] ph);
    logic [phase_bits-1:0] full;
    int half;
    half = 1 << (phase_bits - 1);
    if (!ph[phase_bits-1]) begin
      full = phase_bits'(half + 2 * int'(ph[phase_bits-2:0]));
    end else begin
      full = phase_bits'(half - 1 - 2 * int'(ph[phase_bits-2:0]));
    end
    return full[phase_bits-1 -: sample_width];
  endfunction

  // quadrant rule: whole word on the rising half and straddling mid-scale
  function automatic logic crossing_rule(input triangle_pkg::phase_word_t pw, input int ch);
    logic any_upper;
    logic any_quad;
    logic all_quad;
    any_upper = 1'b0;
    any_quad  = 1'b0;
    all_quad  = 1'b1;
    for (int s = 0; s < parallel_samples; s++) begin
      any_upper = any_upper | pw.phase[ch][s][phase_bits-1];
      any_quad  = any_quad | pw.phase[ch][s][phase_bits-2];
      all_quad  = all_quad & pw.phase[ch][s][phase_bits-2];
    end
    return !any_upper && any_quad && !all_quad;
  endfunction

  function automatic triangle_pkg::dac_word_t expected_word(
    input triangle_pkg::phase_word_t pw, input logic v);
    triangle_pkg::dac_word_t w;
    w = '0;
    w.valid = v;
    for (int ch = 0; ch < channels; ch++) begin
      w.trigger[ch] = crossing_rule(pw, ch);
      for (int s = 0; s < parallel_samples; s++) begin
        // idle words carry zero samples
        if (v) begin
          w.data[ch][s] = fold_sample(pw.phase[ch][s]);
        end
      end
    end
    return w;
  endfunction

  always @(posedge dac_clk) begin
    if (dac_reset) begin
      m_inc    <= '0;
      m_cycle  <= '0;
      m_phase  <= '0;
      m_valid  <= 1'b0;
      d1_phase <= '0;
      d2_phase <= '0;
      d1_valid <= 1'b0;
      d2_valid <= 1'b0;
    end else begin
      if (phase_inc_load) begin
        m_inc <= phase_inc;
      end
      for (int ch = 0; ch < channels; ch++) begin
        m_cycle[ch] <= phase_bits'(m_cycle[ch] + m_inc[ch] * parallel_samples);
        for (int s = 0; s < parallel_samples; s++) begin
          m_phase.phase[ch][s] <= phase_bits'(m_cycle[ch] + m_inc[ch] * s);
        end
      end
      m_valid  <= 1'b1;
      d1_phase <= m_phase;
      d1_valid <= m_valid;
      d2_phase <= d1_phase;
      d2_valid <= d1_valid;
    end
  end

  always_comb begin
    exp_word = expected_word(d2_phase, d2_valid);
    for (int ch = 0; ch < channels; ch++) begin
      for (int s = 0; s < parallel_samples; s++) begin
        mid_fill[ch][s] = sample_width'(1 << (sample_width - 1));
      end
    end
  end

  always @(posedge dac_clk) begin
    cycle_count <= cycle_count + 1;
    if (dac_reset) begin
      edges_since_release <= 0;
    end else if (edges_since_release < 3) begin
      edges_since_release <= edges_since_release + 1;
    end
  end

  always @(posedge dac_clk) begin
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // valid rises on the third edge after release
  valid_level_check: assert property (@(posedge dac_clk)
    (cycle_count != 0) |-> (dac_out.valid == (edges_since_release >= 3)))
    else begin
      valid_errs++;
      $display("error %s: valid expected %0b actual %0b", test_name,
               $sampled(edges_since_release >= 3), $sampled(dac_out.valid));
    end

  valid_hold_check: assert property (@(posedge dac_clk) disable iff (dac_reset)
    dac_out.valid |=> dac_out.valid)
    else begin
      valid_errs++;
      $display("error %s: valid expected 1 actual 0 after it was high", test_name);
    end

  idle_word_check: assert property (@(posedge dac_clk)
    (cycle_count != 0 && !dac_out.valid) |-> (dac_out == '0))
    else begin
      idle_errs++;
      $display("error %s: idle word expected 0 actual %h", test_name, $sampled(dac_out));
    end

  data_check: assert property (@(posedge dac_clk)
    (cycle_count != 0) |-> (dac_out.data == exp_word.data))
    else begin
      data_errs++;
      $display("error %s: data expected %h actual %h", test_name,
               $sampled(exp_word.data), $sampled(dac_out.data));
    end

  trigger_check: assert property (@(posedge dac_clk)
    (cycle_count != 0) |-> (dac_out.trigger == exp_word.trigger))
    else begin
      trig_errs++;
      $display("error %s: trigger expected %b actual %b", test_name,
               $sampled(exp_word.trigger), $sampled(dac_out.trigger));
    end

  // generator stage, pins down exactly which word a reload hits
  phase_check: assert property (@(posedge dac_clk)
    (cycle_count != 0) |-> (dut_i.phase_gen_i.phase_word == m_phase))
    else begin
      phase_errs++;
      $display("error %s: phase word expected %h actual %h", test_name,
               $sampled(m_phase), $sampled(dut_i.phase_gen_i.phase_word));
    end

  zero_inc_check: assert property (@(posedge dac_clk)
    (test_id == 2 && dac_out.valid) |-> (dac_out.data == mid_fill && dac_out.trigger == '0))
    else begin
      data_errs++;
      $display("error %s: word expected %h actual %h", test_name,
               {{channels{1'b0}}, mid_fill}, $sampled({dac_out.trigger, dac_out.data}));
    end

  task automatic next_cycle();
    @(posedge dac_clk);
    #1;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  // one-cycle strobe, the bus is scrambled afterwards since it is ignored
  task automatic load_increment(input triangle_pkg::phase_inc_t inc);
    phase_inc      = inc;
    phase_inc_load = 1'b1;
    next_cycle();
    phase_inc_load = 1'b0;
    for (int ch = 0; ch < channels; ch++) begin
      phase_inc[ch] = phase_bits'($urandom());
    end
  endtask

  task automatic check_trigger_period();
    triangle_pkg::phase_inc_t slow_inc;
    int window [channels];
    int hits [channels];
    int step;
    int longest;
    longest = 0;
    // restart from phase zero so the first crossing is predictable
    dac_reset = 1'b1;
    run_cycles(4);
    dac_reset = 1'b0;
    run_cycles(4);
    for (int ch = 0; ch < channels; ch++) begin
      // mid-scale must land inside a word, not in the gap between two words
      do begin
        slow_inc[ch] = phase_bits'(4096 + ($urandom() % 4096));
        step = parallel_samples * int'(slow_inc[ch]);
      end while ((quarter % step) == 0 || (quarter % step) > step - int'(slow_inc[ch]));
      window[ch] = (full_scale + step - 1) / step;
      hits[ch] = 0;
      if (window[ch] > longest) begin
        longest = window[ch];
      end
    end
    load_increment(slow_inc);
    // first word of the period reaches dac_out three edges after the load
    // edge, counting starts one zero-phase word early
    run_cycles(1);
    for (int n = 0; n <= longest; n++) begin
      next_cycle();
      for (int ch = 0; ch < channels; ch++) begin
        if (n <= window[ch] && dac_out.trigger[ch]) begin
          hits[ch]++;
        end
      end
    end
    for (int ch = 0; ch < channels; ch++) begin
      crossing_count_check: assert (hits[ch] == 1)
      else begin
        trig_errs++;
        $display("error %s: channel %0d crossings per period expected 1 actual %0d",
                 test_name, ch, hits[ch]);
      end
    end
  endtask

  initial begin
    triangle_pkg::phase_inc_t first_inc;
    triangle_pkg::phase_inc_t second_inc;
    int total;
    void'($urandom(24));
    dac_reset      = 1'b1;
    phase_inc_load = 1'b0;
    phase_inc      = '0;
    test_id        = 1;
    test_name      = "reset";
    repeat (4) @(posedge dac_clk);
    #1;
    dac_reset = 1'b0;
    run_cycles(reset_cycles - 4);

    test_id   = 2;
    test_name = "zero_inc";
    run_cycles(zero_cycles);

    test_id   = 3;
    test_name = "shape";
    for (int ch = 0; ch < channels; ch++) begin
      first_inc[ch] = phase_bits'($urandom());
    end
    load_increment(first_inc);
    run_cycles(shape_cycles);

    // reload mid-stream, accumulator keeps running
    test_id   = 4;
    test_name = "reload";
    for (int ch = 0; ch < channels; ch++) begin
      do begin
        second_inc[ch] = phase_bits'($urandom());
      end while (second_inc[ch] == first_inc[ch]);
    end
    load_increment(second_inc);
    run_cycles(reload_cycles);

    test_id   = 5;
    test_name = "trigger";
    check_trigger_period();
    run_cycles(2);

    total = valid_errs + idle_errs + data_errs + trig_errs + phase_errs;
    $display("check summary: valid %0d, idle %0d, data %0d, trigger %0d, phase %0d errors",
             valid_errs, idle_errs, data_errs, trig_errs, phase_errs);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
hw/triangle_pkg.sv
hw/parallel_phase_gen.sv
hw/triangle_shaper.sv
hw/crossing_detector.sv
hw/sample_combiner.sv
hw/triangle_gen_top.sv
tb/triangle_gen_tb.sv

// File: Bender.yml
package:
  name: triangle_gen

sources:
  - files:
      - hw/triangle_pkg.sv
      - hw/parallel_phase_gen.sv
      - hw/triangle_shaper.sv
      - hw/crossing_detector.sv
      - hw/sample_combiner.sv
      - hw/triangle_gen_top.sv
  - target: test
    files:
      - tb/triangle_gen_tb.sv
